//--- rtl/bridge_bus_pkg.sv
package bridge_bus_pkg;

  // message field width on the shared bus
  localparam int msg_w = 8;

  // no message this cycle
  localparam logic [msg_w-1:0] msg_void = 8'h00;
  // core finished bring-up, index captured
  localparam logic [msg_w-1:0] msg_reset = 8'h01;
  // core took a thread, peers shift their position
  localparam logic [msg_w-1:0] msg_start = 8'h02;
  // core gave up its thread
  localparam logic [msg_w-1:0] msg_end = 8'h03;

  // relation code width
  localparam int rel_w = 2;

  // nothing compared yet, or token already returned
  localparam logic [rel_w-1:0] rel_none = 2'd0;
  // offered position below own position
  localparam logic [rel_w-1:0] rel_lower = 2'd1;
  // offered position above own position
  localparam logic [rel_w-1:0] rel_higher = 2'd2;
  // full match, active bit included
  localparam logic [rel_w-1:0] rel_equal = 2'd3;

endpackage

//--- rtl/core_state_pkg.sv
package core_state_pkg;

  // core FSM state code width
  localparam int state_w = 4;

  // core FSM states seen by the bridge
  localparam logic [state_w-1:0] wait_for_start = 4'd0;
  localparam logic [state_w-1:0] start_begin = 4'd1;
  localparam logic [state_w-1:0] read_cond = 4'd2;
  localparam logic [state_w-1:0] read_src1 = 4'd3;
  localparam logic [state_w-1:0] read_src0 = 4'd4;
  localparam logic [state_w-1:0] start_read_cmd = 4'd5;
  localparam logic [state_w-1:0] write_reg_ip = 4'd6;
  localparam logic [state_w-1:0] write_dst = 4'd7;
  localparam logic [state_w-1:0] write_src1 = 4'd8;
  localparam logic [state_w-1:0] write_src0 = 4'd9;
  localparam logic [state_w-1:0] write_cond = 4'd10;
  localparam logic [state_w-1:0] finish_begin = 4'd11;
  localparam logic [state_w-1:0] finish_end = 4'd12;
  localparam logic [state_w-1:0] idle_state = 4'd13;

  // states that fetch over the bus
  function automatic logic is_read_state(input logic [state_w-1:0] code);
    return code inside {read_cond, read_src1, read_src0, start_read_cmd};
  endfunction

  // states that store over the bus
  function automatic logic is_write_state(input logic [state_w-1:0] code);
    return code inside {write_reg_ip, write_dst, write_src1, write_src0, write_cond};
  endfunction

  // bring-up steps
  localparam int rst_step_w = 3;
  localparam logic [rst_step_w-1:0] step_enter = 3'd0;
  localparam logic [rst_step_w-1:0] step_choose = 3'd1;
  localparam logic [rst_step_w-1:0] step_capture = 3'd2;
  localparam logic [rst_step_w-1:0] step_pulse = 3'd3;
  localparam logic [rst_step_w-1:0] step_release = 3'd4;
  localparam logic [rst_step_w-1:0] step_run = 3'd5;

endpackage

//--- rtl/reset_sequencer.sv
`timescale 1ns/10ps

module reset_sequencer (
  input  logic                               clk,
  input  logic                               ext_rst_b,
  input  logic [core_state_pkg::state_w-1:0] core_state,
  input  logic                               restart,
  output logic                               run,
  output logic                               capture_index,
  output logic                               seq_rst,
  output logic                               ext_rst_e,
  output logic                               reset_msg
);
  import core_state_pkg::*;

  logic [rst_step_w-1:0] step;
  logic                  thread_done;

  // core came back from a finished thread, index is already known
  assign thread_done = (core_state == finish_end);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step      <= step_enter;
      seq_rst   <= 1'b0;
      ext_rst_e <= 1'b0;
    end else begin
      // reset pulses last one cycle
      seq_rst   <= 1'b0;
      ext_rst_e <= 1'b0;
      case (step)
        step_enter: begin
          step <= step_choose;
        end
        step_choose: begin
          // skip index capture after a finished thread
          step <= thread_done ? step_pulse : step_capture;
        end
        step_capture: begin
          step <= step_pulse;
        end
        step_pulse: begin
          seq_rst <= 1'b1;
          // bus reset only on a cold bring-up
          ext_rst_e <= !thread_done;
          step      <= step_release;
        end
        step_release: begin
          step <= step_run;
        end
        step_run: begin
          if (restart) begin
            step <= step_enter;
          end
        end
        default: begin
          step <= step_enter;
        end
      endcase
    end
  end

  assign run           = (step == step_run);
  // index load and reset message share the capture step
  assign capture_index = (step == step_capture);
  assign reset_msg     = (step == step_capture);

endmodule

//--- rtl/peer_compare.sv
`timescale 1ns/10ps

module peer_compare #(
  parameter int index_w = 32
) (
  input  logic                             clk,
  input  logic                             ext_rst_b,
  input  logic                             ext_next_cpu_q,
  input  logic [index_w-1:0]               ext_cpu_index,
  input  logic [index_w-1:0]               own_index,
  input  logic                             next_cpu_e,
  output logic [bridge_bus_pkg::rel_w-1:0] ind_rel
);
  import bridge_bus_pkg::*;

  // queue position is everything below the active flag
  localparam int pos_w = index_w - 1;

  logic [pos_w-1:0] offer_pos;
  logic [pos_w-1:0] own_pos;

  assign offer_pos = ext_cpu_index[pos_w-1:0];
  assign own_pos   = own_index[pos_w-1:0];

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ind_rel <= rel_none;
    end else if (ext_next_cpu_q) begin
      // positions first, full index only when positions tie
      if (offer_pos < own_pos) begin
        ind_rel <= rel_lower;
      end else if (offer_pos > own_pos) begin
        ind_rel <= rel_higher;
      end else if (ext_cpu_index == own_index) begin
        ind_rel <= rel_equal;
      end
      // same position, other active flag keeps last code
    end else if (next_cpu_e) begin
      // offer withdrawn after our ack
      ind_rel <= rel_none;
    end
  end

endmodule

//--- rtl/token_dispatch.sv
`timescale 1ns/10ps

module token_dispatch #(
  parameter int index_w = 32
) (
  input  logic                               clk,
  input  logic                               ext_rst_b,
  input  logic                               run,
  input  logic                               reset_msg,
  input  logic [core_state_pkg::state_w-1:0] core_state,
  input  logic                               bus_busy,
  input  logic                               ext_next_cpu_q,
  input  logic [index_w-1:0]                 ext_cpu_index,
  input  logic [bridge_bus_pkg::rel_w-1:0]   ind_rel,
  input  logic [index_w-1:0]                 own_index,
  input  logic                               read_q,
  input  logic                               write_q,
  output logic                               token_hit,
  output logic                               release_index,
  output logic                               ext_next_cpu_e,
  output logic [bridge_bus_pkg::msg_w-1:0]   ext_cpu_msg,
  output logic [index_w-1:0]                 ext_cpu_index_out,
  output logic                               disp_online,
  output logic                               next_state,
  output logic                               ext_dispatcher_q,
  output logic                               ext_read_q,
  output logic                               ext_write_q
);
  import bridge_bus_pkg::*;
  import core_state_pkg::*;

  logic dispatch_r;
  logic rw_pending;
  logic claim;
  logic announce;
  logic step_ok;

  // token is ours once the registered compare says equal
  assign token_hit  = ext_next_cpu_q && (ind_rel == rel_equal);
  // a hit still being acked is not a new claim
  assign claim      = token_hit && !ext_next_cpu_e;
  assign announce   = claim && (core_state == wait_for_start || core_state == finish_begin);
  assign rw_pending = read_q || write_q;
  // running and not stalled by the bus
  assign step_ok    = run && !bus_busy;

  // finished thread gives its index back and restarts bring-up
  assign release_index = step_ok && !token_hit && (core_state == finish_end);

  // high from the end of bring-up, then follows the read and write states
  assign ext_dispatcher_q = run && dispatch_r;

  // requests pass only while online and in a matching state
  assign ext_read_q  = disp_online && is_read_state(core_state) && read_q;
  assign ext_write_q = disp_online && is_write_state(core_state) && write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_next_cpu_e <= 1'b0;
      ext_cpu_msg    <= msg_void;
      disp_online    <= 1'b0;
      next_state     <= 1'b0;
      dispatch_r     <= 1'b0;
    end else if (!run) begin
      // bring-up ack, own index against the offer
      ext_next_cpu_e <= ext_next_cpu_q && (ext_cpu_index == own_index);
      ext_cpu_msg    <= reset_msg ? msg_reset : msg_void;
      disp_online    <= 1'b0;
      next_state     <= 1'b0;
      dispatch_r     <= 1'b1;
    end else if (!bus_busy) begin
      ext_cpu_msg <= msg_void;
      next_state  <= 1'b0;
      dispatch_r  <= is_read_state(core_state) || is_write_state(core_state);
      // keep the token while the core still talks to the bus
      if (disp_online) begin
        if (rw_pending) begin
          ext_next_cpu_e <= 1'b1;
        end else if (ext_next_cpu_e) begin
          ext_next_cpu_e <= 1'b0;
          disp_online    <= 1'b0;
        end
      end
      if (claim) begin
        disp_online <= 1'b1;
      end
      // start or end of a thread, tell the peers and move the core on
      if (announce) begin
        ext_cpu_msg    <= (core_state == wait_for_start) ? msg_start : msg_end;
        ext_next_cpu_e <= 1'b1;
        next_state     <= 1'b1;
      end
    end
  end

  // index sent along with the announcement
  always_ff @(posedge clk) begin
    if (step_ok && announce) begin
      ext_cpu_index_out <= own_index;
    end
  end

endmodule

//--- rtl/index_tracker.sv
`timescale 1ns/10ps

module index_tracker #(
  parameter int index_w = 32
) (
  input  logic                               clk,
  input  logic                               ext_rst_b,
  input  logic                               capture_index,
  input  logic                               run,
  input  logic                               token_hit,
  input  logic                               release_index,
  input  logic                               bus_busy,
  input  logic [core_state_pkg::state_w-1:0] core_state,
  input  logic [index_w-1:0]                 ext_cpu_index,
  input  logic [bridge_bus_pkg::msg_w-1:0]   ext_cpu_msg_in,
  output logic [index_w-1:0]                 own_index
);
  import bridge_bus_pkg::*;
  import core_state_pkg::*;

  localparam int pos_w = index_w - 1;

  logic             peer_active;
  logic             own_active;
  logic [pos_w-1:0] peer_pos;
  logic [pos_w-1:0] own_pos;

  // top bit is the active flag
  assign peer_active = ext_cpu_index[index_w-1];
  assign own_active  = own_index[index_w-1];
  assign peer_pos    = ext_cpu_index[pos_w-1:0];
  assign own_pos     = own_index[pos_w-1:0];

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else if (capture_index) begin
      // index handed out on the bus during bring-up
      own_index <= ext_cpu_index;
    end else if (run && !bus_busy) begin
      if (release_index) begin
        own_index <= '0;
      end else if (token_hit && core_state == start_begin && own_index == '0) begin
        // first thread on an unnumbered core, just mark it active
        own_index[index_w-1] <= 1'b1;
      end else if (ext_cpu_msg_in == msg_end && peer_active && own_active &&
                   peer_pos < own_pos) begin
        // an active core ahead of us left the queue
        own_index[pos_w-1:0] <= own_pos - 1'b1;
      end else if (ext_cpu_msg_in == msg_start && !peer_active) begin
        // idle peer started, active cores move back, idle ones move up
        own_index[pos_w-1:0] <= own_active ? own_pos + 1'b1 : own_pos - 1'b1;
      end
    end
  end

endmodule

//--- rtl/cpu_bus_bridge.sv
`timescale 1ns/10ps

module cpu_bus_bridge #(
  parameter int index_w = 32
) (
  input  logic                               clk,
  input  logic                               ext_rst_b,
  input  logic [core_state_pkg::state_w-1:0] core_state,
  input  logic                               read_q,
  input  logic                               write_q,
  input  logic                               bus_busy,
  input  logic                               ext_next_cpu_q,
  input  logic [index_w-1:0]                 ext_cpu_index,
  input  logic [bridge_bus_pkg::msg_w-1:0]   ext_cpu_msg_in,
  output logic                               ext_next_cpu_e,
  output logic [bridge_bus_pkg::msg_w-1:0]   ext_cpu_msg,
  output logic [index_w-1:0]                 ext_cpu_index_out,
  output logic                               disp_online,
  output logic                               next_state,
  output logic                               ext_dispatcher_q,
  output logic                               ext_read_q,
  output logic                               ext_write_q,
  output logic                               core_rst,
  output logic                               ext_rst_e,
  output logic [bridge_bus_pkg::rel_w-1:0]   cpu_ind_rel
);

  logic               run;
  logic               capture_index;
  logic               reset_msg;
  logic               token_hit;
  logic               release_index;
  logic [index_w-1:0] own_index;

  // bring-up, restarted by a released index
  reset_sequencer u_reset_sequencer (
    .clk           (clk),
    .ext_rst_b     (ext_rst_b),
    .core_state    (core_state),
    .restart       (release_index),
    .run           (run),
    .capture_index (capture_index),
    .seq_rst       (core_rst),
    .ext_rst_e     (ext_rst_e),
    .reset_msg     (reset_msg)
  );

  // compare stage, next offer can sit here while a token is acked
  peer_compare #(
    .index_w (index_w)
  ) u_peer_compare (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .ext_next_cpu_q (ext_next_cpu_q),
    .ext_cpu_index  (ext_cpu_index),
    .own_index      (own_index),
    .next_cpu_e     (ext_next_cpu_e),
    .ind_rel        (cpu_ind_rel)
  );

  // dispatch stage
  token_dispatch #(
    .index_w (index_w)
  ) u_token_dispatch (
    .clk               (clk),
    .ext_rst_b         (ext_rst_b),
    .run               (run),
    .reset_msg         (reset_msg),
    .core_state        (core_state),
    .bus_busy          (bus_busy),
    .ext_next_cpu_q    (ext_next_cpu_q),
    .ext_cpu_index     (ext_cpu_index),
    .ind_rel           (cpu_ind_rel),
    .own_index         (own_index),
    .read_q            (read_q),
    .write_q           (write_q),
    .token_hit         (token_hit),
    .release_index     (release_index),
    .ext_next_cpu_e    (ext_next_cpu_e),
    .ext_cpu_msg       (ext_cpu_msg),
    .ext_cpu_index_out (ext_cpu_index_out),
    .disp_online       (disp_online),
    .next_state        (next_state),
    .ext_dispatcher_q  (ext_dispatcher_q),
    .ext_read_q        (ext_read_q),
    .ext_write_q       (ext_write_q)
  );

  // track stage, own queue position
  index_tracker #(
    .index_w (index_w)
  ) u_index_tracker (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .capture_index  (capture_index),
    .run            (run),
    .token_hit      (token_hit),
    .release_index  (release_index),
    .bus_busy       (bus_busy),
    .core_state     (core_state),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .own_index      (own_index)
  );

endmodule

//--- tests/cpu_bus_bridge_checker.sv
`timescale 1ns/10ps

module cpu_bus_bridge_checker #(
  parameter int index_w = 32
) (
  input logic                             clk,
  input logic                             ext_rst_b,
  input logic                             bus_busy,
  input logic                             next_state,
  input logic                             ext_rst_e,
  input logic                             core_rst,
  input logic                             ext_next_cpu_e,
  input logic                             ext_dispatcher_q,
  input logic                             disp_online,
  input logic                             ext_read_q,
  input logic                             ext_write_q,
  input logic [bridge_bus_pkg::msg_w-1:0] ext_cpu_msg,
  input logic [index_w-1:0]               own_index
);
  import bridge_bus_pkg::*;

  // failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // announce pulse, a stall may freeze it
  a_next_state_pulse: assert property (
    @(posedge clk) (next_state && !bus_busy) |=> !next_state
  ) else begin
    fail_count++;
    $error("next_state high for more than one cycle");
  end

  // bus reset is a single-cycle pulse
  a_ext_rst_e_pulse: assert property (
    @(posedge clk) ext_rst_e |=> !ext_rst_e
  ) else begin
    fail_count++;
    $error("ext_rst_e high for more than one cycle");
  end

  // all control outputs and the index cleared by reset
  a_reset_clears: assert property (
    @(posedge clk) ext_rst_b |=> (!ext_next_cpu_e && !ext_dispatcher_q && !disp_online &&
      !next_state && !core_rst && !ext_rst_e && !ext_read_q && !ext_write_q &&
      ext_cpu_msg == msg_void && own_index == '0)
  ) else begin
    fail_count++;
    $error("control output not cleared one cycle after reset");
  end

  // no bus request while offline
  a_gated_requests: assert property (
    @(posedge clk) (ext_read_q || ext_write_q) |-> disp_online
  ) else begin
    fail_count++;
    $error("bus request while disp_online low");
  end

endmodule

bind cpu_bus_bridge cpu_bus_bridge_checker #(
  .index_w (index_w)
) u_checker (
  .clk              (clk),
  .ext_rst_b        (ext_rst_b),
  .bus_busy         (bus_busy),
  .next_state       (next_state),
  .ext_rst_e        (ext_rst_e),
  .core_rst         (core_rst),
  .ext_next_cpu_e   (ext_next_cpu_e),
  .ext_dispatcher_q (ext_dispatcher_q),
  .disp_online      (disp_online),
  .ext_read_q       (ext_read_q),
  .ext_write_q      (ext_write_q),
  .ext_cpu_msg      (ext_cpu_msg),
  .own_index        (own_index)
);

//--- tests/tb_cpu_bus_bridge.sv
`timescale 1ns/10ps

module tb_cpu_bus_bridge;
  import bridge_bus_pkg::*;
  import core_state_pkg::*;

  localparam int index_w = 32;
  localparam int pos_w = index_w - 1;
  localparam int wait_limit = 20;

  logic                 clk;
  logic                 ext_rst_b;
  logic [state_w-1:0]   core_state;
  logic                 read_q;
  logic                 write_q;
  logic                 bus_busy;
  logic                 ext_next_cpu_q;
  logic [index_w-1:0]   ext_cpu_index;
  logic [msg_w-1:0]     ext_cpu_msg_in;
  logic                 ext_next_cpu_e;
  logic [msg_w-1:0]     ext_cpu_msg;
  logic [index_w-1:0]   ext_cpu_index_out;
  logic                 disp_online;
  logic                 next_state;
  logic                 ext_dispatcher_q;
  logic                 ext_read_q;
  logic                 ext_write_q;
  logic                 core_rst;
  logic                 ext_rst_e;
  logic [rel_w-1:0]     cpu_ind_rel;
  int                   errors;
  logic [index_w-1:0]   own_idx;
  logic [pos_w-1:0]     pos;

  cpu_bus_bridge #(
    .index_w (index_w)
  ) u_cpu_bus_bridge (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // called at a falling edge, leaves reset on a falling edge
  task automatic apply_reset(input logic [state_w-1:0] st, input logic [index_w-1:0] idx);
    ext_rst_b = 1'b1;
    core_state = st;
    ext_cpu_index = idx;
    repeat (3) @(negedge clk);
    ext_rst_b = 1'b0;
  endtask

  // bounded wait on the token acknowledge
  task automatic wait_ack(input logic level, input string what, output int cycles);
    cycles = 0;
    while (ext_next_cpu_e !== level && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (ext_next_cpu_e !== level) begin
      errors++;
      $display("timeout while waiting for %s", what);
    end
  endtask

  // offer for one cycle, relation code expected one edge later
  task automatic offer_index(input logic [index_w-1:0] idx, input logic [rel_w-1:0] exp);
    ext_next_cpu_q = 1'b1;
    ext_cpu_index = idx;
    @(negedge clk);
    check_value("cpu_ind_rel", cpu_ind_rel, exp);
    ext_next_cpu_q = 1'b0;
    @(negedge clk);
  endtask

  // one cycle of a peer message on the bus
  task automatic peer_message(input logic [msg_w-1:0] msg, input logic [index_w-1:0] idx);
    ext_cpu_msg_in = msg;
    ext_cpu_index = idx;
    @(negedge clk);
    ext_cpu_msg_in = msg_void;
  endtask

  function automatic logic read_class(input logic [state_w-1:0] st);
    case (st)
      read_cond, read_src1, read_src0, start_read_cmd: read_class = 1'b1;
      default: read_class = 1'b0;
    endcase
  endfunction

  function automatic logic write_class(input logic [state_w-1:0] st);
    case (st)
      write_reg_ip, write_dst, write_src1, write_src0, write_cond: write_class = 1'b1;
      default: write_class = 1'b0;
    endcase
  endfunction

  initial begin
    int                 cyc;
    int                 chk_fails;
    logic [state_w-1:0] st;
    logic [state_w-1:0] prev_st;
    logic               r;
    logic               w;
    void'($urandom(32'h2103984e));
    errors = 0;
    read_q = 1'b0;
    write_q = 1'b0;
    bus_busy = 1'b0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_msg_in = msg_void;
    pos = pos_w'(16 + $urandom % 1000);
    own_idx = {1'b1, pos};

    // warm bring-up after a finished thread, no bus reset, no capture
    // finish_end in run releases the index and restarts the sequence
    apply_reset(finish_end, index_w'($urandom));
    for (int k = 1; k <= 10; k++) begin
      @(negedge clk);
      check_value("ext_rst_e", ext_rst_e, 1'b0);
      check_value("ext_cpu_msg", ext_cpu_msg, msg_void);
      check_value("core_rst", core_rst, k == 3 || k == 8);
    end

    // cold bring-up, fixed step timing
    apply_reset(wait_for_start, own_idx);
    for (int k = 1; k <= 6; k++) begin
      @(negedge clk);
      check_value("core_rst", core_rst, k == 4);
      check_value("ext_rst_e", ext_rst_e, k == 4);
      check_value("ext_cpu_msg", ext_cpu_msg, (k == 3) ? msg_reset : msg_void);
      check_value("ext_dispatcher_q", ext_dispatcher_q, k == 5);
    end

    // start announcement on our own index
    ext_next_cpu_q = 1'b1;
    @(negedge clk);
    check_value("cpu_ind_rel", cpu_ind_rel, rel_equal);
    check_value("ext_next_cpu_e", ext_next_cpu_e, 1'b0);
    wait_ack(1'b1, "start acknowledge", cyc);
    check_value("ext_next_cpu_e latency", cyc, 1);
    check_value("ext_cpu_msg", ext_cpu_msg, msg_start);
    check_value("ext_cpu_index_out", ext_cpu_index_out, own_idx);
    check_value("next_state", next_state, 1'b1);
    check_value("disp_online", disp_online, 1'b1);
    ext_next_cpu_q = 1'b0;

    // online with random requests, finish_end would release the index
    // dispatcher request follows the state seen at the last edge
    prev_st = wait_for_start;
    for (int i = 0; i < 16; i++) begin
      st = state_w'($urandom % 14);
      if (st == finish_end) begin
        st = idle_state;
      end
      r = 1'($urandom);
      w = 1'($urandom);
      if (!r && !w) begin
        r = 1'b1;
      end
      core_state = st;
      read_q = r;
      write_q = w;
      #1;
      check_value("ext_read_q", ext_read_q, read_class(st) && r);
      check_value("ext_write_q", ext_write_q, write_class(st) && w);
      check_value("ext_dispatcher_q", ext_dispatcher_q,
                  read_class(prev_st) || write_class(prev_st));
      check_value("disp_online", disp_online, 1'b1);
      check_value("ext_next_cpu_e", ext_next_cpu_e, 1'b1);
      prev_st = st;
      @(negedge clk);
    end
    read_q = 1'b0;
    write_q = 1'b0;
    core_state = idle_state;
    wait_ack(1'b0, "token release", cyc);
    check_value("disp_online", disp_online, 1'b0);

    // relation codes, idle so nothing is claimed
    offer_index({1'b1, pos - pos_w'(1 + $urandom % 8)}, rel_lower);
    offer_index({1'b0, pos + pos_w'(1 + $urandom % 8)}, rel_higher);

    // idle peer starts, active own position moves back by one
    peer_message(msg_start, {1'b0, pos_w'($urandom)});
    offer_index(own_idx, rel_lower);
    // active peer ahead of us ends, position returns
    peer_message(msg_end, {1'b1, pos - pos_w'($urandom % 4)});
    offer_index({1'b1, pos + 1'b1}, rel_higher);

    // stalled bus holds the dispatch stage
    core_state = wait_for_start;
    bus_busy = 1'b1;
    ext_next_cpu_q = 1'b1;
    ext_cpu_index = own_idx;
    repeat (4) begin
      @(negedge clk);
      check_value("disp_online", disp_online, 1'b0);
      check_value("next_state", next_state, 1'b0);
      check_value("ext_cpu_msg", ext_cpu_msg, msg_void);
    end
    bus_busy = 1'b0;
    wait_ack(1'b1, "acknowledge after stall", cyc);
    check_value("ext_next_cpu_e latency", cyc, 1);
    check_value("ext_cpu_msg", ext_cpu_msg, msg_start);
    check_value("next_state", next_state, 1'b1);
    check_value("disp_online", disp_online, 1'b1);
    ext_next_cpu_q = 1'b0;
    wait_ack(1'b0, "token release after stall", cyc);
    check_value("disp_online", disp_online, 1'b0);

    @(negedge clk);
    chk_fails = u_cpu_bus_bridge.u_checker.fail_count;
    $display("errors: %0d check failures, %0d assertion failures", errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
rtl/bridge_bus_pkg.sv
rtl/core_state_pkg.sv
rtl/reset_sequencer.sv
rtl/peer_compare.sv
rtl/token_dispatch.sv
rtl/index_tracker.sv
rtl/cpu_bus_bridge.sv
tests/cpu_bus_bridge_checker.sv
tests/tb_cpu_bus_bridge.sv
